// File: list.f
verilog/flash_pkg.sv
verilog/spi_byte_if.sv
verilog/spi_byte_shifter.sv
verilog/page_program_seq.sv
verilog/flash_prog_top.sv
tb/spi_flash_model.sv
tb/tb_flash_prog.sv

// File: tb/flash_prog_input.txt
# addr(hex) data(hex) busy_reads second_start(0/1) wip_timeout(0/1)
# wip_timeout column assumes MAX_POLLS = 8
012345 a7 0 0 0
00ff10 3c 1 0 0
abcdef 55 3 1 0
7f0080 00 7 0 0
100001 ff 8 0 1
2000fe 81 10 1 1
0300fe 4e 2 0 0
fedc42 c3 5 1 0
000000 99 12 0 1

// File: tb/spi_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

// Mode 0 SPI flash slave, only enough of it for WREN, PP and RDSR
module spi_flash_model (
    input  logic spi_sck,
    input  logic spi_mosi,
    input  logic spi_cs_n,
    output logic spi_miso,
    input  int   busy_reads    // RDSR reads with WIP set after each PP
);
    import flash_pkg::*;

    byte_t             mem [0:255];
    logic              wel        = 1'b0;
    logic              wip        = 1'b0;
    int                busy_left  = 0;
    byte_t             rx_sh      = 8'h00;
    byte_t             tx_sh      = 8'hff;
    int                bit_cnt    = 0;
    int                byte_idx   = 0;
    byte_t             cmd        = 8'h00;
    logic [ADDR_W-1:0] pp_addr    = '0;
    byte_t             pp_data    = 8'h00;
    int                wren_cnt   = 0;
    int                pp_cnt     = 0;
    int                rdsr_cnt   = 0;
    int                frame_cnt  = 0;
    int                wren_frame = -1;
    int                pp_frame   = -1;

    initial begin
        spi_miso = 1'b1;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'ha5;
        end
    end

    always @(negedge spi_cs_n) begin
        bit_cnt  = 0;
        byte_idx = 0;
        cmd      = 8'h00;
        tx_sh    = 8'hff;
    end

    always @(posedge spi_sck) begin
        if (!spi_cs_n) begin
            rx_sh   = {rx_sh[6:0], spi_mosi};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8) begin
                bit_cnt = 0;
                if (byte_idx == 0) begin
                    cmd = rx_sh;
                end else if (cmd == CMD_PP && byte_idx <= 3) begin
                    pp_addr = {pp_addr[ADDR_W-9:0], rx_sh};    // Address MSB first
                end else if (cmd == CMD_PP && byte_idx == 4) begin
                    pp_data = rx_sh;
                end
                byte_idx = byte_idx + 1;
            end
        end
    end

    always @(negedge spi_sck) begin
        if (!spi_cs_n) begin
            if (cmd == CMD_RDSR && byte_idx == 1 && bit_cnt == 0) begin
                tx_sh = 8'h00;
                tx_sh[STATUS_WEL] = wel;
                tx_sh[STATUS_WIP] = wip;
            end else begin
                tx_sh = {tx_sh[6:0], 1'b1};
            end
            spi_miso = tx_sh[7];
        end
    end

    // Commands take effect when the frame ends
    always @(posedge spi_cs_n) begin
        if (byte_idx > 0) begin
            frame_cnt = frame_cnt + 1;
            if (cmd == CMD_WREN) begin
                wren_cnt   = wren_cnt + 1;
                wren_frame = frame_cnt;
                wel        = 1'b1;
            end else if (cmd == CMD_PP) begin
                pp_cnt   = pp_cnt + 1;
                pp_frame = frame_cnt;
                if (wel && byte_idx >= 5) begin
                    mem[pp_addr[7:0]] = pp_data;    // One page only
                    busy_left         = busy_reads;
                    wip               = (busy_reads > 0);
                    wel               = (busy_reads > 0);
                end
            end else if (cmd == CMD_RDSR) begin
                rdsr_cnt = rdsr_cnt + 1;
                if (wip && byte_idx >= 2) begin
                    busy_left = busy_left - 1;
                    if (busy_left == 0) begin
                        wip = 1'b0;
                        wel = 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_flash_prog.sv
`timescale 1ns/1ps
`default_nettype none

module tb_flash_prog;
    import flash_pkg::*;

    localparam int HALF      = 5;
    localparam int MAX_POLLS = 8;

    logic              sys_clk;
    logic              sys_rst_n;
    logic              start;
    logic [ADDR_W-1:0] addr;
    byte_t             wr_data;
    logic              busy;
    logic              done;
    byte_t             status;
    logic              wip_timeout;
    logic              spi_sck;
    logic              spi_mosi;
    logic              spi_cs_n;
    logic              spi_miso;
    int                busy_reads;

    logic [ADDR_W-1:0] test_addr[$];
    byte_t             test_data[$];
    int                test_busy[$];
    bit                test_second[$];
    bit                test_tmo[$];
    int                n_tests   = 0;
    int                check_cnt = 0;
    int                error_cnt = 0;

    flash_prog_top #(
        .HALF        (HALF),
        .MAX_POLLS   (MAX_POLLS)
    ) i_dut (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .start       (start),
        .addr        (addr),
        .wr_data     (wr_data),
        .busy        (busy),
        .done        (done),
        .status      (status),
        .wip_timeout (wip_timeout),
        .spi_sck     (spi_sck),
        .spi_mosi    (spi_mosi),
        .spi_cs_n    (spi_cs_n),
        .spi_miso    (spi_miso)
    );

    spi_flash_model i_flash (
        .spi_sck    (spi_sck),
        .spi_mosi   (spi_mosi),
        .spi_cs_n   (spi_cs_n),
        .spi_miso   (spi_miso),
        .busy_reads (busy_reads)
    );

    always #50 sys_clk = ~sys_clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_cnt++;
        assert (actual === expected) else begin
            error_cnt++;
            $display("** Error: %s expected %0h, got %0h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        check_cnt++;
        assert (cond) else begin
            error_cnt++;
            $display("Error: %s at %0t", what, $time);
        end
    endtask

    // Columns: addr, data, busy reads, second start flag, expected timeout
    task automatic load_tests();
        int                fd;
        int                n;
        string             line;
        logic [ADDR_W-1:0] a;
        byte_t             d;
        int                b;
        int                s;
        int                t;
        fd = $fopen("tb/flash_prog_input.txt", "r");
        if (fd == 0) begin
            error_cnt++;
            $display("Error: cannot open tb/flash_prog_input.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%h %h %d %d %d", a, d, b, s, t);
                if (line[0] != "#" && n == 5) begin
                    test_addr.push_back(a);
                    test_data.push_back(d);
                    test_busy.push_back(b);
                    test_second.push_back(s != 0);
                    test_tmo.push_back(t != 0);
                end
            end
            $fclose(fd);
            if (test_addr.size() == 0) begin
                error_cnt++;
                $display("Error: no tests found in the input file");
            end
            n_tests = test_addr.size();
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic run_test(input int idx);
        logic [ADDR_W-1:0] a;
        int                wren0;
        int                pp0;
        int                rdsr0;
        int                exp_rdsr;
        int                extra;
        a        = test_addr[idx];
        wren0    = i_flash.wren_cnt;
        pp0      = i_flash.pp_cnt;
        rdsr0    = i_flash.rdsr_cnt;
        exp_rdsr = (test_busy[idx] + 1 < MAX_POLLS) ? test_busy[idx] + 1 : MAX_POLLS;
        busy_reads = test_busy[idx];
        start   = 1'b1;
        addr    = a;
        wr_data = test_data[idx];
        @(negedge sys_clk);
        start = 1'b0;
        check_value("busy", 1, busy);
        if (test_second[idx]) begin
            repeat (3) @(negedge sys_clk);
            check_true(busy === 1'b1, "DUT not busy when the second start was driven");
            start   = 1'b1;
            addr    = a ^ 24'h0f0f0f;
            wr_data = ~test_data[idx];
            @(negedge sys_clk);
            start = 1'b0;
        end
        while (done !== 1'b1) @(negedge sys_clk);
        check_value("busy", 0, busy);
        check_value("wip_timeout", test_tmo[idx], wip_timeout);
        check_true(test_tmo[idx] == (test_busy[idx] >= MAX_POLLS),
                   "timeout flag in the input file does not match MAX_POLLS");
        if (test_tmo[idx]) begin
            // WEL stays set while the program runs
            check_value("status", (1 << STATUS_WEL) | (1 << STATUS_WIP), status);
        end else begin
            check_value("status", 8'h00, status);
        end
        check_value("mem", test_data[idx], i_flash.mem[a[7:0]]);
        check_value("pp_addr", a, i_flash.pp_addr);
        check_value("wren_frames", 1, i_flash.wren_cnt - wren0);
        check_value("pp_frames", 1, i_flash.pp_cnt - pp0);
        check_value("rdsr_frames", exp_rdsr, i_flash.rdsr_cnt - rdsr0);
        check_true(i_flash.wren_frame < i_flash.pp_frame, "WREN frame did not come before PP");
        extra = 0;
        repeat (4 * HALF) begin
            @(negedge sys_clk);
            if (done !== 1'b0 || busy !== 1'b0) extra++;
        end
        check_true(extra == 0, "done or busy seen again after the operation ended");
    endtask

    task automatic close_run();
        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin
        sys_clk    = 1'b0;
        sys_rst_n  = 1'b0;
        start      = 1'b0;
        addr       = '0;
        wr_data    = '0;
        busy_reads = 0;
        load_tests();
        if (n_tests > 0) begin
            repeat (2) @(posedge sys_clk);
            @(negedge sys_clk);
            sys_rst_n = 1'b1;
            @(negedge sys_clk);
            check_value("spi_cs_n", 1, spi_cs_n);
            check_value("spi_sck", 0, spi_sck);
            check_value("spi_mosi", 1, spi_mosi);
            check_value("busy", 0, busy);
            check_value("done", 0, done);
            check_value("status", 8'h00, status);
            check_value("wip_timeout", 0, wip_timeout);
            for (int i = 0; i < n_tests; i++) begin
                run_test(i);
            end
        end
        close_run();
    end

    // Longest case is every test running out of polls
    initial begin
        longint limit_ns;
        wait (n_tests > 0);
        limit_ns = longint'(n_tests) * (8 + 2 * MAX_POLLS) * 18 * HALF * 100 + 100_000;
        #(limit_ns);
        error_cnt++;
        $display("Error: timeout, run still going after %0d ns", limit_ns);
        close_run();
    end

endmodule

`default_nettype wire

// File: verilog/flash_pkg.sv
`default_nettype none

package flash_pkg;

    // One byte on the SPI wires
    typedef logic [7:0] byte_t;

    // Three address bytes, sent MSB first
    localparam int ADDR_W = 24;

    // Flash commands used by the page-program sequence
    localparam byte_t CMD_WREN = 8'h06;   // Write enable
    localparam byte_t CMD_PP   = 8'h02;   // Page program
    localparam byte_t CMD_RDSR = 8'h05;   // Read status register

    // Status register bits
    localparam int STATUS_WIP = 0;        // Program still running
    localparam int STATUS_WEL = 1;        // Set by WREN, cleared when program ends

endpackage

`default_nettype wire

// File: verilog/flash_prog_top.sv
`timescale 1ns/1ps
`default_nettype none

module flash_prog_top #(
    parameter int HALF      = 5,    // SCK half period in sys_clk cycles
    parameter int MAX_POLLS = 8
) (
    input  logic                         sys_clk,
    input  logic                         sys_rst_n,
    input  logic                         start,
    input  logic [flash_pkg::ADDR_W-1:0] addr,
    input  flash_pkg::byte_t             wr_data,
    output logic                         busy,
    output logic                         done,
    output flash_pkg::byte_t             status,
    output logic                         wip_timeout,
    output logic                         spi_sck,
    output logic                         spi_mosi,
    output logic                         spi_cs_n,
    input  logic                         spi_miso
);

    // Byte requests from sequencer to shifter
    spi_byte_if bus_if ();

    page_program_seq #(
        .MAX_POLLS   (MAX_POLLS)
    ) i_seq (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .start       (start),
        .addr        (addr),
        .wr_data     (wr_data),
        .bus         (bus_if.seq),
        .busy        (busy),
        .done        (done),
        .status      (status),
        .wip_timeout (wip_timeout)
    );

    spi_byte_shifter #(
        .HALF        (HALF)
    ) i_shf (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .bus         (bus_if.shf),
        .spi_miso    (spi_miso),
        .spi_sck     (spi_sck),
        .spi_mosi    (spi_mosi),
        .spi_cs_n    (spi_cs_n)
    );

endmodule

`default_nettype wire

// File: verilog/page_program_seq.sv
`timescale 1ns/1ps
`default_nettype none

module page_program_seq #(
    parameter int MAX_POLLS = 8    // RDSR frames before giving up
) (
    input  logic                         sys_clk,
    input  logic                         sys_rst_n,
    input  logic                         start,
    input  logic [flash_pkg::ADDR_W-1:0] addr,
    input  flash_pkg::byte_t             wr_data,
    spi_byte_if.seq                      bus,
    output logic                         busy,
    output logic                         done,
    output flash_pkg::byte_t             status,
    output logic                         wip_timeout
);
    import flash_pkg::*;

    localparam int POLL_W = $clog2(MAX_POLLS + 1);
    localparam logic [POLL_W-1:0] POLL_LAST = POLL_W'(MAX_POLLS - 1);

    // Each state names the byte currently in flight
    typedef enum logic [3:0] {
        S_IDLE,
        S_WREN,
        S_PP_OP,
        S_ADDR_H,
        S_ADDR_M,
        S_ADDR_L,
        S_DATA,
        S_RDSR_OP,
        S_RDSR_RD
    } state_t;

    state_t            state;
    logic [POLL_W-1:0] poll_cnt;    // RDSR frames already finished
    logic [ADDR_W-1:0] addr_q;
    byte_t             data_q;

    logic start_ok;
    logic wip_set;
    logic last_poll;

    assign start_ok  = (state == S_IDLE) && start;
    assign wip_set   = bus.rx_byte[STATUS_WIP];
    assign last_poll = (poll_cnt == POLL_LAST);

    // Request taken only when idle
    always_ff @(posedge sys_clk) begin
        if (start_ok) begin
            addr_q <= addr;
            data_q <= wr_data;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state       <= S_IDLE;
            poll_cnt    <= '0;
            busy        <= 1'b0;
            done        <= 1'b0;
            status      <= '0;
            wip_timeout <= 1'b0;
            bus.go      <= 1'b0;
            bus.tx_byte <= '0;
            bus.last    <= 1'b0;
        end else begin
            bus.go <= 1'b0;
            done   <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start_ok) begin
                        busy        <= 1'b1;
                        state       <= S_WREN;
                        bus.go      <= 1'b1;
                        bus.tx_byte <= CMD_WREN;
                        bus.last    <= 1'b1;    // WREN is a frame of its own
                    end
                end
                S_WREN: begin
                    if (bus.done) begin
                        state       <= S_PP_OP;
                        bus.go      <= 1'b1;
                        bus.tx_byte <= CMD_PP;
                        bus.last    <= 1'b0;
                    end
                end
                S_PP_OP: begin
                    if (bus.done) begin
                        state       <= S_ADDR_H;
                        bus.go      <= 1'b1;
                        bus.tx_byte <= addr_q[ADDR_W-1 -: 8];
                        bus.last    <= 1'b0;
                    end
                end
                S_ADDR_H: begin
                    if (bus.done) begin
                        state       <= S_ADDR_M;
                        bus.go      <= 1'b1;
                        bus.tx_byte <= addr_q[ADDR_W-9 -: 8];
                        bus.last    <= 1'b0;
                    end
                end
                S_ADDR_M: begin
                    if (bus.done) begin
                        state       <= S_ADDR_L;
                        bus.go      <= 1'b1;
                        bus.tx_byte <= addr_q[7:0];
                        bus.last    <= 1'b0;
                    end
                end
                S_ADDR_L: begin
                    if (bus.done) begin
                        state       <= S_DATA;
                        bus.go      <= 1'b1;
                        bus.tx_byte <= data_q;
                        bus.last    <= 1'b1;    // CS rise starts the program
                    end
                end
                S_DATA: begin
                    if (bus.done) begin
                        state       <= S_RDSR_OP;
                        poll_cnt    <= '0;
                        bus.go      <= 1'b1;
                        bus.tx_byte <= CMD_RDSR;
                        bus.last    <= 1'b0;
                    end
                end
                S_RDSR_OP: begin
                    if (bus.done) begin
                        state       <= S_RDSR_RD;
                        bus.go      <= 1'b1;
                        bus.tx_byte <= 8'hFF;   // Dummy while status shifts in
                        bus.last    <= 1'b1;
                    end
                end
                S_RDSR_RD: begin
                    if (bus.done) begin
                        if (!wip_set || last_poll) begin
                            // Finished or out of polls
                            state       <= S_IDLE;
                            busy        <= 1'b0;
                            done        <= 1'b1;
                            status      <= bus.rx_byte;
                            wip_timeout <= wip_set;
                        end else begin
                            state       <= S_RDSR_OP;
                            poll_cnt    <= poll_cnt + 1'b1;
                            bus.go      <= 1'b1;
                            bus.tx_byte <= CMD_RDSR;
                            bus.last    <= 1'b0;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/spi_byte_if.sv
`timescale 1ns/1ps
`default_nettype none

// One byte per request, frame ends after a byte with last set
interface spi_byte_if ();
    import flash_pkg::*;

    logic  go;        // Single cycle request
    logic  last;
    byte_t tx_byte;
    byte_t rx_byte;   // Held until the next done
    logic  done;

    modport seq (
        output go,
        output tx_byte,
        output last,
        input  rx_byte,
        input  done
    );

    modport shf (
        input  go,
        input  tx_byte,
        input  last,
        output rx_byte,
        output done
    );

endinterface

`default_nettype wire

// File: verilog/spi_byte_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_shifter #(
    parameter int HALF = 5    // Cycles per SCK half period, 2 or more
) (
    input  logic    sys_clk,
    input  logic    sys_rst_n,
    spi_byte_if.shf bus,
    input  logic    spi_miso,
    output logic    spi_sck,
    output logic    spi_mosi,
    output logic    spi_cs_n
);
    import flash_pkg::*;

    localparam int CNT_W = $clog2(2 * HALF);
    localparam logic [CNT_W-1:0] PH_END = CNT_W'(HALF - 1);
    localparam logic [CNT_W-1:0] DS_END = CNT_W'(2 * HALF - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_DESEL
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] hcnt;      // Cycles within a half period
    logic [2:0]       bit_cnt;
    logic             last_q;
    byte_t            tx_sh;
    byte_t            rx_sh;

    logic start_byte;
    logic sck_rise;
    logic sck_fall;
    logic byte_fin;
    logic desel_end;
    logic byte_done;

    assign start_byte = (state == ST_IDLE) && bus.go;
    assign sck_rise   = (state == ST_SHIFT) && (hcnt == PH_END) && !spi_sck;
    assign sck_fall   = (state == ST_SHIFT) && (hcnt == PH_END) && spi_sck;
    assign byte_fin   = sck_fall && (bit_cnt == 3'd7);
    assign desel_end  = (state == ST_DESEL) && (hcnt == DS_END);
    assign byte_done  = (byte_fin && !last_q) || desel_end;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state    <= ST_IDLE;
            hcnt     <= '0;
            bit_cnt  <= '0;
            last_q   <= 1'b0;
            spi_sck  <= 1'b0;
            spi_mosi <= 1'b1;
            spi_cs_n <= 1'b1;
            bus.done <= 1'b0;
        end else begin
            bus.done <= byte_done;
            case (state)
                ST_IDLE: begin
                    if (start_byte) begin
                        state    <= ST_SHIFT;
                        hcnt     <= CNT_W'(1);     // MOSI set up here already
                        bit_cnt  <= '0;
                        last_q   <= bus.last;
                        spi_cs_n <= 1'b0;
                        spi_mosi <= bus.tx_byte[7];
                    end
                end
                ST_SHIFT: begin
                    if (hcnt != PH_END) begin
                        hcnt <= hcnt + 1'b1;
                    end else begin
                        hcnt    <= '0;
                        spi_sck <= !spi_sck;
                        if (spi_sck) begin
                            // Falling edge, next bit goes out
                            if (bit_cnt == 3'd7) begin
                                bit_cnt <= '0;
                                if (last_q) begin
                                    state    <= ST_DESEL;
                                    spi_cs_n <= 1'b1;
                                    spi_mosi <= 1'b1;
                                end else begin
                                    state <= ST_IDLE;   // CS stays low
                                end
                            end else begin
                                bit_cnt  <= bit_cnt + 1'b1;
                                spi_mosi <= tx_sh[6];
                            end
                        end
                    end
                end
                ST_DESEL: begin
                    // Deselect time before the frame counts as done
                    if (desel_end) begin
                        state <= ST_IDLE;
                    end else begin
                        hcnt <= hcnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (start_byte) begin
            tx_sh <= bus.tx_byte;
        end else if (sck_fall) begin
            tx_sh <= {tx_sh[6:0], 1'b0};
        end
        if (sck_rise) begin
            rx_sh <= {rx_sh[6:0], spi_miso};    // Sample on SCK rise
        end
        if (byte_done) begin
            bus.rx_byte <= rx_sh;
        end
    end

endmodule

`default_nettype wire
